// ==== wb_bus_pkg.sv ====
// Wishbone bus widths
// request and response structs shared by masters, interconnect and slaves

package wb_bus_pkg;

	localparam int WB_ADDR_W = 32;
	localparam int WB_DATA_W = 32;
	localparam int WB_SEL_W  = WB_DATA_W / 8;

	// master to slave, held steady until ack or err
	typedef struct packed {
		logic                 cyc;
		logic                 stb;
		logic                 we;
		logic [WB_SEL_W-1:0]  sel;
		logic [WB_ADDR_W-1:0] adr;
		logic [WB_DATA_W-1:0] dat;
	} wb_req_t;

	// slave to master, ack and err are single-cycle pulses
	typedef struct packed {
		logic                 ack;
		logic                 err;
		logic [WB_DATA_W-1:0] dat;
	} wb_rsp_t;

endpackage

// ==== wb_map_pkg.sv ====
// address map types
// slave-select encoding and slave count used by the decoder

package wb_map_pkg;

	localparam int WB_NUM_SLAVES = 2;

	// result of decoding one master address
	// SEL_NONE means no window matched and the cycle ends in err
	typedef enum logic [1:0] {
		SEL_S0   = 2'd0,
		SEL_S1   = 2'd1,
		SEL_NONE = 2'd2
	} wb_slave_sel_t;

endpackage

// ==== wb_slave_arbiter.sv ====
// two-master round-robin arbiter for one slave port
// grant is registered and held for the whole bus cycle

`timescale 1ns/1ps

module wb_slave_arbiter (
	input  logic       clk,
	input  logic       rst_n,
	input  logic [1:0] req,
	output logic [1:0] grant
);

	logic [1:0] grant_next;
	// 0 when master 0 was the last one granted, 1 for master 1
	logic       last_win;
	logic       owner_active;

	assign owner_active = |(grant & req);

	always_comb begin
		grant_next = grant;
		// a new decision only once the current owner has let go
		if (!owner_active) begin
			case (req)
				2'b01:   grant_next = 2'b01;
				2'b10:   grant_next = 2'b10;
				// both asking, the one that lost last time goes first
				2'b11:   grant_next = last_win ? 2'b01 : 2'b10;
				default: grant_next = 2'b00;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			grant    <= 2'b00;
			last_win <= 1'b0;
		end else begin
			grant <= grant_next;
			if (grant_next != 2'b00) begin
				last_win <= grant_next[1];
			end
		end
	end

	// never more than one owner per slave
	a_grant_onehot: assert property (
		@(posedge clk) disable iff (!rst_n)
		$onehot0(grant)
	);

	// ownership lasts as long as the owner keeps its cycle open
	a_grant_held: assert property (
		@(posedge clk) disable iff (!rst_n)
		owner_active |=> (grant == $past(grant))
	);

endmodule

// ==== wb_interconnect_2x2.sv ====
// 2x2 Wishbone interconnect
// address decode, one arbiter per slave, request mux, response routing
// and a one-cycle error response for unmapped addresses

`timescale 1ns/1ps

module wb_interconnect_2x2 #(
	parameter logic [wb_bus_pkg::WB_ADDR_W-1:0] S0_BASE  = 32'h0000_0000,
	parameter logic [wb_bus_pkg::WB_ADDR_W-1:0] S0_LIMIT = 32'h0000_0fff,
	parameter logic [wb_bus_pkg::WB_ADDR_W-1:0] S1_BASE  = 32'h0000_1000,
	parameter logic [wb_bus_pkg::WB_ADDR_W-1:0] S1_LIMIT = 32'h0000_1fff
) (
	input  logic                clk,
	input  logic                rst_n,
	input  wb_bus_pkg::wb_req_t m0_req,
	input  wb_bus_pkg::wb_req_t m1_req,
	output wb_bus_pkg::wb_rsp_t m0_rsp,
	output wb_bus_pkg::wb_rsp_t m1_rsp,
	output wb_bus_pkg::wb_req_t s0_req,
	output wb_bus_pkg::wb_req_t s1_req,
	input  wb_bus_pkg::wb_rsp_t s0_rsp,
	input  wb_bus_pkg::wb_rsp_t s1_rsp
);

	import wb_bus_pkg::*;
	import wb_map_pkg::*;

	wb_slave_sel_t m0_sel;
	wb_slave_sel_t m1_sel;
	logic [1:0]    arb_req [WB_NUM_SLAVES];
	logic [1:0]    arb_gnt [WB_NUM_SLAVES];
	wb_req_t       s_req_mux [WB_NUM_SLAVES];
	// per master error pulse for unmapped accesses
	logic [1:0]    err_q;

	function automatic wb_slave_sel_t decode(input logic [WB_ADDR_W-1:0] adr);
		if (adr >= S0_BASE && adr <= S0_LIMIT) begin
			return SEL_S0;
		end
		if (adr >= S1_BASE && adr <= S1_LIMIT) begin
			return SEL_S1;
		end
		return SEL_NONE;
	endfunction

	// response of the slave this master owns, with the decode error merged in
	function automatic wb_rsp_t route(input wb_rsp_t rsp0, input wb_rsp_t rsp1,
		input logic own_s0, input logic own_s1, input logic err_now);
		wb_rsp_t rsp;
		rsp = '0;
		if (own_s0) begin
			rsp = rsp0;
		end else if (own_s1) begin
			rsp = rsp1;
		end
		rsp.err = rsp.err | err_now;
		return rsp;
	endfunction

	assign m0_sel = decode(m0_req.adr);
	assign m1_sel = decode(m1_req.adr);

	for (genvar s = 0; s < WB_NUM_SLAVES; s++) begin : g_slave
		// a master wants this slave while its cycle is open and the address hits
		assign arb_req[s] = {
			m1_req.cyc && (m1_sel == wb_slave_sel_t'(s)),
			m0_req.cyc && (m0_sel == wb_slave_sel_t'(s))
		};

		wb_slave_arbiter arb_inst (
			.clk   (clk),
			.rst_n (rst_n),
			.req   (arb_req[s]),
			.grant (arb_gnt[s])
		);

		// idle slave ports see all zeros, so cyc and stb stay low
		assign s_req_mux[s] = arb_gnt[s][0] ? m0_req :
			arb_gnt[s][1] ? m1_req : '0;
	end

	assign s0_req = s_req_mux[0];
	assign s1_req = s_req_mux[1];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			err_q <= 2'b00;
		end else begin
			err_q[0] <= m0_req.cyc && m0_req.stb && (m0_sel == SEL_NONE) && !err_q[0];
			err_q[1] <= m1_req.cyc && m1_req.stb && (m1_sel == SEL_NONE) && !err_q[1];
		end
	end

	assign m0_rsp = route(s0_rsp, s1_rsp, arb_gnt[0][0], arb_gnt[1][0], err_q[0]);
	assign m1_rsp = route(s0_rsp, s1_rsp, arb_gnt[0][1], arb_gnt[1][1], err_q[1]);

	// the mux must never hand a strobe to a slave outside an open cycle
	a_s0_stb_in_cyc: assert property (
		@(posedge clk) disable iff (!rst_n)
		s0_req.stb |-> s0_req.cyc
	);

	a_s1_stb_in_cyc: assert property (
		@(posedge clk) disable iff (!rst_n)
		s1_req.stb |-> s1_req.cyc
	);

endmodule

// ==== wb_sram.sv ====
// Wishbone SRAM slave
// word addressed, byte-select writes, fixed single-cycle ack

`timescale 1ns/1ps

module wb_sram #(
	parameter int MEM_ADDR_BITS = 10
) (
	input  logic                clk,
	input  logic                rst_n,
	input  wb_bus_pkg::wb_req_t req,
	output wb_bus_pkg::wb_rsp_t rsp
);

	import wb_bus_pkg::*;

	logic [WB_DATA_W-1:0]     mem [2**MEM_ADDR_BITS];
	logic [MEM_ADDR_BITS-1:0] word_idx;
	logic [WB_DATA_W-1:0]     rd_q;
	logic                     ack_q;
	logic                     access;

	// byte address to word index, upper bits ignored so the window wraps
	assign word_idx = req.adr[MEM_ADDR_BITS+1:2];

	// a strobe seen in the ack cycle belongs to the access just acked
	assign access = req.cyc && req.stb && !ack_q;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= access;
		end
	end

	// write lands on the edge that raises ack, read data comes out with ack
	always_ff @(posedge clk) begin
		if (access) begin
			if (req.we) begin
				for (int b = 0; b < WB_SEL_W; b++) begin
					if (req.sel[b]) begin
						mem[word_idx][8*b +: 8] <= req.dat[8*b +: 8];
					end
				end
			end
			rd_q <= mem[word_idx];
		end
	end

	assign rsp.ack = ack_q;
	assign rsp.err = 1'b0;
	assign rsp.dat = rd_q;

	a_ack_pulse: assert property (
		@(posedge clk) disable iff (!rst_n)
		ack_q |=> !ack_q
	);

endmodule

// ==== wb_sys_top.sv ====
// top level of the Wishbone subsystem
// 2x2 interconnect with one SRAM behind each slave port

`timescale 1ns/1ps

module wb_sys_top #(
	parameter logic [wb_bus_pkg::WB_ADDR_W-1:0] S0_BASE  = 32'h0000_0000,
	parameter logic [wb_bus_pkg::WB_ADDR_W-1:0] S0_LIMIT = 32'h0000_0fff,
	parameter logic [wb_bus_pkg::WB_ADDR_W-1:0] S1_BASE  = 32'h0000_1000,
	parameter logic [wb_bus_pkg::WB_ADDR_W-1:0] S1_LIMIT = 32'h0000_1fff,
	parameter int                               MEM_ADDR_BITS = 10
) (
	input  logic                clk,
	input  logic                rst_n,
	input  wb_bus_pkg::wb_req_t m0_req,
	input  wb_bus_pkg::wb_req_t m1_req,
	output wb_bus_pkg::wb_rsp_t m0_rsp,
	output wb_bus_pkg::wb_rsp_t m1_rsp
);

	import wb_bus_pkg::*;

	wb_req_t s0_req;
	wb_req_t s1_req;
	wb_rsp_t s0_rsp;
	wb_rsp_t s1_rsp;

	wb_interconnect_2x2 #(
		.S0_BASE  (S0_BASE),
		.S0_LIMIT (S0_LIMIT),
		.S1_BASE  (S1_BASE),
		.S1_LIMIT (S1_LIMIT)
	) ic_inst (
		.clk    (clk),
		.rst_n  (rst_n),
		.m0_req (m0_req),
		.m1_req (m1_req),
		.m0_rsp (m0_rsp),
		.m1_rsp (m1_rsp),
		.s0_req (s0_req),
		.s1_req (s1_req),
		.s0_rsp (s0_rsp),
		.s1_rsp (s1_rsp)
	);

	// slave 0, lower window
	wb_sram #(
		.MEM_ADDR_BITS (MEM_ADDR_BITS)
	) sram0_inst (
		.clk   (clk),
		.rst_n (rst_n),
		.req   (s0_req),
		.rsp   (s0_rsp)
	);

	// slave 1, upper window
	wb_sram #(
		.MEM_ADDR_BITS (MEM_ADDR_BITS)
	) sram1_inst (
		.clk   (clk),
		.rst_n (rst_n),
		.req   (s1_req),
		.rsp   (s1_rsp)
	);

endmodule

// ==== tb_clk_gen.sv ====
// testbench clock, free running from time zero

`timescale 1ns/1ps

module tb_clk_gen #(
	parameter int PERIOD_NS = 20
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever begin
			#(PERIOD_NS / 2) clk = ~clk;
		end
	end

endmodule

// ==== wb_sys_tb.sv ====
// Wishbone subsystem testbench
// two master models, a memory model, directed and seeded random traffic

`timescale 1ns/1ps

module wb_sys_tb;

	import wb_bus_pkg::*;

	localparam int RSP_TIMEOUT = 50;

	logic    clk;
	logic    rst_n;
	wb_req_t m0_req;
	wb_req_t m1_req;
	wb_rsp_t m0_rsp;
	wb_rsp_t m1_rsp;

	// word address to expected contents, holds only words written so far
	logic [31:0] model [logic [31:0]];
	int          completed [2];
	int          checks;
	int          errors;
	int          test_errors;
	int          tests_run;
	int          tests_bad;

	tb_clk_gen clk_gen_inst (.clk(clk));

	wb_sys_top wb_sys_top_inst (
		.clk    (clk),
		.rst_n  (rst_n),
		.m0_req (m0_req),
		.m1_req (m1_req),
		.m0_rsp (m0_rsp),
		.m1_rsp (m1_rsp)
	);

	task automatic check_data(input string name, input wb_rsp_t got,
		input logic [WB_DATA_W-1:0] exp);
		checks++;
		if (got.dat !== exp) begin
			errors++;
			$display("[ERROR] %s got %08h expected %08h", name, got.dat, exp);
		end
	endtask

	task automatic check_err(input string name, input wb_rsp_t got, input logic exp);
		checks++;
		if (got.err !== exp) begin
			errors++;
			$display("[ERROR] %s got %0h expected %0h", name, got.err, exp);
		end
	endtask

	task automatic check_ack(input string name, input wb_rsp_t got, input logic exp);
		checks++;
		if (got.ack !== exp) begin
			errors++;
			$display("[ERROR] %s got %0h expected %0h", name, got.ack, exp);
		end
	endtask

	function automatic logic [31:0] word_key(input logic [31:0] adr);
		return {2'b00, adr[31:2]};
	endfunction

	// only the selected bytes of the word change
	function automatic void model_write(input logic [31:0] adr, input logic [3:0] sel,
		input logic [31:0] dat);
		logic [31:0] word;
		word = model.exists(word_key(adr)) ? model[word_key(adr)] : 32'h0;
		for (int b = 0; b < 4; b++) begin
			if (sel[b]) begin
				word[8*b +: 8] = dat[8*b +: 8];
			end
		end
		model[word_key(adr)] = word;
	endfunction

	function automatic wb_req_t make_req(input logic we, input logic [31:0] adr,
		input logic [3:0] sel, input logic [31:0] dat);
		wb_req_t r;
		r.cyc = 1'b1;
		r.stb = 1'b1;
		r.we  = we;
		r.sel = sel;
		r.adr = adr;
		r.dat = dat;
		return r;
	endfunction

	task automatic wait_rsp(input int m, output wb_rsp_t rsp, output logic done);
		int cycles;
		done   = 1'b0;
		rsp    = '0;
		cycles = 0;
		while (!done && cycles < RSP_TIMEOUT) begin
			@(negedge clk);
			cycles++;
			rsp = (m == 0) ? m0_rsp : m1_rsp;
			if (rsp.ack || rsp.err) begin
				done = 1'b1;
			end
		end
		if (!done) begin
			errors++;
			$display("master %0d saw neither ack nor err within %0d cycles", m, RSP_TIMEOUT);
		end
	endtask

	task automatic m0_access(input logic we, input logic [31:0] adr, input logic [3:0] sel,
		input logic [31:0] dat, output wb_rsp_t rsp, output logic done);
		@(negedge clk);
		m0_req = make_req(we, adr, sel, dat);
		wait_rsp(0, rsp, done);
		// cyc and stb drop together once the cycle has ended
		m0_req = '0;
	endtask

	task automatic m1_access(input logic we, input logic [31:0] adr, input logic [3:0] sel,
		input logic [31:0] dat, output wb_rsp_t rsp, output logic done);
		@(negedge clk);
		m1_req = make_req(we, adr, sel, dat);
		wait_rsp(1, rsp, done);
		m1_req = '0;
	endtask

	task automatic do_access(input int m, input logic we, input logic [31:0] adr,
		input logic [3:0] sel, input logic [31:0] dat, output wb_rsp_t rsp, output logic done);
		if (m == 0) begin
			m0_access(we, adr, sel, dat, rsp, done);
		end else begin
			m1_access(we, adr, sel, dat, rsp, done);
		end
		if (done) begin
			completed[m]++;
		end
	endtask

	task automatic write_word(input int m, input logic [31:0] adr, input logic [3:0] sel,
		input logic [31:0] dat);
		wb_rsp_t rsp;
		logic    done;
		do_access(m, 1'b1, adr, sel, dat, rsp, done);
		model_write(adr, sel, dat);
		if (done) begin
			check_ack($sformatf("m%0d_rsp.ack", m), rsp, 1'b1);
			check_err($sformatf("m%0d_rsp.err", m), rsp, 1'b0);
		end
	endtask

	task automatic read_word(input int m, input logic [31:0] adr);
		wb_rsp_t rsp;
		logic    done;
		do_access(m, 1'b0, adr, 4'hf, 32'h0, rsp, done);
		if (done) begin
			check_ack($sformatf("m%0d_rsp.ack", m), rsp, 1'b1);
			check_err($sformatf("m%0d_rsp.err", m), rsp, 1'b0);
			check_data($sformatf("m%0d_rsp.dat", m), rsp, model[word_key(adr)]);
		end
	endtask

	// unmapped address, expect err and no ack
	task automatic bad_access(input int m, input logic we, input logic [31:0] adr);
		wb_rsp_t rsp;
		logic    done;
		do_access(m, we, adr, 4'hf, 32'hdead_beef, rsp, done);
		if (done) begin
			check_err($sformatf("m%0d_rsp.err", m), rsp, 1'b1);
			check_ack($sformatf("m%0d_rsp.ack", m), rsp, 1'b0);
		end
	endtask

	// window from bit 12, this master's half of the window from bit 11
	task automatic random_traffic(input int m, input int count);
		logic [31:0] adr;
		logic [3:0]  sel;
		for (int i = 0; i < count; i++) begin
			adr = 32'h1000 * $urandom_range(0, 1) + 32'h800 * m + 4 * $urandom_range(0, 31);
			sel = 4'($urandom_range(1, 15));
			if (model.exists(word_key(adr)) && $urandom_range(0, 1) == 1) begin
				read_word(m, adr);
			end else begin
				// first write to a word is a full word, so every byte is known
				if (!model.exists(word_key(adr))) begin
					sel = 4'hf;
				end
				write_word(m, adr, sel, $urandom());
			end
		end
	endtask

	task automatic contend(input int m, input logic [31:0] base, input int count);
		for (int i = 0; i < count; i++) begin
			write_word(m, base + 4 * i, 4'hf, $urandom());
			read_word(m, base + 4 * i);
		end
	endtask

	task automatic finish_test(input int num, input string name);
		tests_run++;
		if (errors == test_errors) begin
			$display("test %0d %s: ok", num, name);
		end else begin
			tests_bad++;
			$display("test %0d %s: %0d errors", num, name, errors - test_errors);
		end
		test_errors = errors;
	endtask

	initial begin
		logic [31:0] key;
		void'($urandom(32'h95ce));
		rst_n       = 1'b0;
		m0_req      = '0;
		m1_req      = '0;
		checks      = 0;
		errors      = 0;
		test_errors = 0;
		tests_run   = 0;
		tests_bad   = 0;
		repeat (10) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		for (int i = 0; i < 5; i++) begin
			@(negedge clk);
			check_ack("m0_rsp.ack", m0_rsp, 1'b0);
			check_err("m0_rsp.err", m0_rsp, 1'b0);
			check_ack("m1_rsp.ack", m1_rsp, 1'b0);
			check_err("m1_rsp.err", m1_rsp, 1'b0);
		end
		finish_test(1, "idle after reset");

		// same offsets in both windows, different values
		write_word(0, 32'h0000_0000, 4'hf, 32'h0a0a_0001);
		write_word(0, 32'h0000_1000, 4'hf, 32'h1b1b_0002);
		write_word(1, 32'h0000_0ffc, 4'hf, 32'h2c2c_0003);
		write_word(1, 32'h0000_1ffc, 4'hf, 32'h3d3d_0004);
		read_word(1, 32'h0000_0000);
		read_word(1, 32'h0000_1000);
		read_word(0, 32'h0000_0ffc);
		read_word(0, 32'h0000_1ffc);
		finish_test(2, "write and read both windows");

		write_word(0, 32'h0000_0040, 4'hf, 32'h1122_3344);
		write_word(0, 32'h0000_0040, 4'b0101, 32'haabb_ccdd);
		write_word(1, 32'h0000_1040, 4'hf, 32'h5566_7788);
		write_word(1, 32'h0000_1040, 4'b1000, 32'h99ee_ffee);
		read_word(1, 32'h0000_0040);
		read_word(0, 32'h0000_1040);
		finish_test(3, "byte select writes");

		// these addresses alias word 0 if the decode lets them through
		bad_access(0, 1'b1, 32'h0000_2000);
		bad_access(1, 1'b0, 32'h0000_2000);
		bad_access(0, 1'b0, 32'h8000_0000);
		bad_access(1, 1'b1, 32'hffff_f000);
		read_word(0, 32'h0000_0000);
		read_word(1, 32'h0000_1000);
		finish_test(4, "unmapped address error");

		fork
			random_traffic(0, 100);
			random_traffic(1, 100);
		join
		if (model.first(key) != 0) begin
			do begin
				read_word(0, {key[29:0], 2'b00});
			end while (model.next(key) != 0);
		end
		finish_test(5, "concurrent random traffic");

		completed[0] = 0;
		completed[1] = 0;
		fork
			contend(0, 32'h0000_1100, 20);
			contend(1, 32'h0000_1900, 20);
		join
		for (int m = 0; m < 2; m++) begin
			if (completed[m] != 40) begin
				errors++;
				$display("master %0d finished only %0d of 40 accesses", m, completed[m]);
			end
		end
		finish_test(6, "no starvation on a shared slave");

		$display("tests: %0d run, %0d with errors, checks: %0d, errors: %0d",
			tests_run, tests_bad, checks, errors);
		if (errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

// ==== tb.f ====
wb_bus_pkg.sv
wb_map_pkg.sv
wb_slave_arbiter.sv
wb_interconnect_2x2.sv
wb_sram.sv
wb_sys_top.sv
tb_clk_gen.sv
wb_sys_tb.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := wb_sys_tb
FILELIST  := tb.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := Result: PASSED

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run, search $(LOG) for the pass line"
	@echo "make clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "make help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || { echo "pass line not found in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
